/* include/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Address and fetch word widths
`define FETCH_XLEN 32
`define FETCH_WIDTH 64

// Two 32-bit instructions per fetch
`define FETCH_STEP 8
`define RESET_PC 0

// Instruction memory
`define ITIM_DEPTH 256
`define ITIM_LATENCY 2

// Branch target table
`define BTAC_DEPTH 16

`endif

/* hdl/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

  typedef logic [`FETCH_XLEN-1:0] addr_t;
  typedef logic [`FETCH_WIDTH-1:0] word_t;

  // ctrl waits out a redirect, inv waits out a fence
  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    ctrl = 2'd2,
    inv  = 2'd3
  } fetch_state_t;

  // Byte offset inside one fetch word
  localparam int FETCH_OFFSET = $clog2(`FETCH_STEP);

  localparam int BTAC_INDEX_W = $clog2(`BTAC_DEPTH);
  localparam int ITIM_INDEX_W = $clog2(`ITIM_DEPTH);

  typedef logic [BTAC_INDEX_W-1:0] btac_index_t;
  typedef logic [ITIM_INDEX_W-1:0] itim_index_t;

  function automatic btac_index_t btac_index(addr_t pc);
    return pc[FETCH_OFFSET +: BTAC_INDEX_W];
  endfunction

  function automatic itim_index_t itim_index(addr_t addr);
    return addr[FETCH_OFFSET +: ITIM_INDEX_W];
  endfunction

endpackage

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_stage import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  trap,
  input  logic  mret,
  input  addr_t mtvec,
  input  addr_t mepc,
  input  logic  fence,
  input  addr_t fence_npc,
  input  logic  clear,
  input  logic  stall,
  input  logic  pred_branch,
  input  addr_t pred_baddr,
  input  addr_t pred_pc,
  input  logic  pred_miss,
  input  addr_t pred_maddr,
  input  logic  mem_ready,
  input  word_t mem_rdata,
  output addr_t get_pc,
  output logic  mem_valid,
  output logic  mem_spec,
  output logic  mem_fence,
  output addr_t mem_addr,
  output logic  fetch_ready,
  output addr_t fetch_pc,
  output addr_t fetch_taddr,
  output addr_t fetch_tpc,
  output word_t fetch_rdata,
  output logic  fetch_taken
);

  fetch_state_t state_q;
  fetch_state_t state_d;
  addr_t        pc_q;
  addr_t        pc_d;
  logic         held_q;
  logic         held_d;
  logic         start_q;

  logic         redirect;
  logic         fence_sel;
  addr_t        redirect_pc;
  logic         pred_hit;
  logic         accept;
  logic         deliver;

  // Lookup runs on the address in flight
  assign get_pc = pc_q;

  //////////////////////////////////////////////////////////////////////
  // Redirect priority
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    redirect    = trap | mret | pred_miss | fence;
    fence_sel   = 1'b0;
    redirect_pc = fence_npc;
    if (trap) begin
      redirect_pc = mtvec;
    end else if (mret) begin
      redirect_pc = mepc;
    end else if (pred_miss) begin
      redirect_pc = pred_maddr;
    end else begin
      fence_sel = fence;
    end
  end

  // Prediction must belong to the pc being fetched
  assign pred_hit = pred_branch && (pred_pc == pc_q);

  // Response belongs to the current stream
  assign accept  = (state_q != idle) && !clear && !redirect;
  assign deliver = accept && (mem_ready || held_q) && !stall;

  //////////////////////////////////////////////////////////////////////
  // Next state and itim request
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    pc_d      = pc_q;
    held_d    = held_q;
    mem_valid = 1'b0;
    mem_spec  = 1'b0;
    mem_fence = 1'b0;
    mem_addr  = pc_q;
    case (state_q)
      idle: begin
        held_d = 1'b0;
        if (redirect) begin
          pc_d = redirect_pc;
        end
        if (start_q && !clear && !stall) begin
          mem_valid = 1'b1;
          mem_addr  = pc_d;
          state_d   = busy;
        end
      end
      busy, ctrl, inv: begin
        if (clear) begin
          // Drop the pending access and park
          state_d  = idle;
          held_d   = 1'b0;
          mem_spec = 1'b1;
          if (redirect) begin
            pc_d = redirect_pc;
          end
        end else if (redirect) begin
          held_d    = 1'b0;
          pc_d      = redirect_pc;
          mem_valid = 1'b1;
          mem_spec  = 1'b1;
          mem_fence = fence_sel;
          mem_addr  = redirect_pc;
          state_d   = fence_sel ? inv : ctrl;
        end else if (deliver) begin
          held_d    = 1'b0;
          pc_d      = pred_hit ? pred_baddr : pc_q + addr_t'(`FETCH_STEP);
          mem_valid = 1'b1;
          mem_spec  = pred_hit;
          mem_addr  = pc_d;
          state_d   = pred_hit ? ctrl : busy;
        end else if (mem_ready) begin
          // Stalled, keep the word until release
          held_d = 1'b1;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q     <= idle;
      pc_q        <= addr_t'(`RESET_PC);
      held_q      <= 1'b0;
      start_q     <= 1'b0;
      fetch_ready <= 1'b0;
    end else begin
      state_q     <= state_d;
      pc_q        <= pc_d;
      held_q      <= held_d;
      start_q     <= !clear;
      fetch_ready <= deliver;
    end
  end

  // Delivered fetch
  always_ff @(posedge clock) begin
    if (accept && mem_ready) begin
      fetch_rdata <= mem_rdata;
    end
    if (deliver) begin
      fetch_pc    <= pc_q;
      fetch_taken <= pred_hit;
      fetch_taddr <= pred_hit ? pred_baddr : '0;
      fetch_tpc   <= pred_hit ? pred_pc : '0;
    end
  end

  // A fence request always carries a new strobe
  fence_has_strobe: assert property (
    @(posedge clock) disable iff (!reset)
    (mem_spec && mem_fence) |-> mem_valid
  );

endmodule

/* hdl/btac.sv */
`timescale 1ns/1ps

`include "fetch_consts.svh"

module btac import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  clear,
  input  addr_t get_pc,
  input  logic  resolve_valid,
  input  logic  resolve_taken,
  input  addr_t resolve_pc,
  input  addr_t resolve_target,
  input  logic  resolve_predicted,
  input  addr_t resolve_ptarget,
  output logic  pred_branch,
  output addr_t pred_baddr,
  output addr_t pred_pc,
  output logic  pred_miss,
  output addr_t pred_maddr
);

  logic [`BTAC_DEPTH-1:0] valid_q;
  addr_t                  tag_q    [`BTAC_DEPTH];
  addr_t                  target_q [`BTAC_DEPTH];

  btac_index_t            get_index;
  btac_index_t            upd_index;

  logic                   hit_q;
  addr_t                  hit_pc_q;
  addr_t                  hit_target_q;

  assign get_index = btac_index(get_pc);
  assign upd_index = btac_index(resolve_pc);

  //////////////////////////////////////////////////////////////////////
  // Training
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      valid_q <= '0;
    end else if (resolve_valid) begin
      // Not-taken resolve evicts the entry
      valid_q[upd_index] <= resolve_taken;
    end
  end

  always_ff @(posedge clock) begin
    if (resolve_valid && resolve_taken) begin
      tag_q[upd_index]    <= resolve_pc;
      target_q[upd_index] <= resolve_target;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= !clear && valid_q[get_index] && (tag_q[get_index] == get_pc);
    end
  end

  always_ff @(posedge clock) begin
    hit_pc_q     <= tag_q[get_index];
    hit_target_q <= target_q[get_index];
  end

  assign pred_branch = hit_q;
  assign pred_baddr  = hit_target_q;
  assign pred_pc     = hit_pc_q;

  // Wrong direction, or taken to the wrong place
  always_comb begin
    pred_miss = 1'b0;
    if (resolve_valid) begin
      if (resolve_taken != resolve_predicted) begin
        pred_miss = 1'b1;
      end else if (resolve_taken && (resolve_target != resolve_ptarget)) begin
        pred_miss = 1'b1;
      end
    end
    pred_maddr = resolve_taken ? resolve_target : resolve_pc + addr_t'(`FETCH_STEP);
  end

  // Emptied table must not predict on the following lookup
  no_hit_after_clear: assert property (
    @(posedge clock) disable iff (!reset)
    clear |=> !pred_branch
  );

endmodule

/* hdl/itim.sv */
`timescale 1ns/1ps

`include "fetch_consts.svh"

module itim import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  load_valid,
  input  addr_t load_addr,
  input  word_t load_data,
  input  logic  mem_valid,
  input  logic  mem_spec,
  input  logic  mem_fence,
  input  addr_t mem_addr,
  output logic  mem_ready,
  output word_t mem_rdata
);

  localparam int COUNT_W = $clog2(`ITIM_LATENCY + 1);

  word_t              mem [`ITIM_DEPTH];
  logic [COUNT_W-1:0] count_q;
  addr_t              addr_q;

  // Load port
  always_ff @(posedge clock) begin
    if (load_valid) begin
      mem[itim_index(load_addr)] <= load_data;
    end
  end

  // New strobe wins over a cancel in the same cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      count_q <= '0;
    end else if (mem_valid) begin
      count_q <= COUNT_W'(`ITIM_LATENCY);
    end else if (mem_spec || mem_fence) begin
      count_q <= '0;
    end else if (count_q != '0) begin
      count_q <= count_q - COUNT_W'(1);
    end
  end

  always_ff @(posedge clock) begin
    if (mem_valid) begin
      addr_q <= mem_addr;
    end
  end

  assign mem_ready = (count_q == COUNT_W'(1));
  assign mem_rdata = mem[itim_index(addr_q)];

  // No response can leak out of reset
  no_ready_after_reset: assert property (
    @(posedge clock)
    !reset |=> !mem_ready
  );

endmodule

/* hdl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  trap,
  input  logic  mret,
  input  addr_t mtvec,
  input  addr_t mepc,
  input  logic  fence,
  input  addr_t fence_npc,
  input  logic  clear,
  input  logic  stall,
  input  logic  resolve_valid,
  input  addr_t resolve_pc,
  input  logic  resolve_taken,
  input  addr_t resolve_target,
  input  logic  resolve_predicted,
  input  addr_t resolve_ptarget,
  input  logic  load_valid,
  input  addr_t load_addr,
  input  word_t load_data,
  output logic  fetch_ready,
  output addr_t fetch_pc,
  output word_t fetch_rdata,
  output logic  fetch_taken,
  output addr_t fetch_taddr,
  output addr_t fetch_tpc
);

  addr_t get_pc;
  logic  pred_branch;
  addr_t pred_baddr;
  addr_t pred_pc;
  logic  pred_miss;
  addr_t pred_maddr;

  logic  mem_valid;
  logic  mem_spec;
  logic  mem_fence;
  addr_t mem_addr;
  logic  mem_ready;
  word_t mem_rdata;

  fetch_stage fetch_stage_i (
    .clock       (clock),
    .reset       (reset),
    .trap        (trap),
    .mret        (mret),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .fence       (fence),
    .fence_npc   (fence_npc),
    .clear       (clear),
    .stall       (stall),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_pc     (pred_pc),
    .pred_miss   (pred_miss),
    .pred_maddr  (pred_maddr),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .get_pc      (get_pc),
    .mem_valid   (mem_valid),
    .mem_spec    (mem_spec),
    .mem_fence   (mem_fence),
    .mem_addr    (mem_addr),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_taddr (fetch_taddr),
    .fetch_tpc   (fetch_tpc),
    .fetch_rdata (fetch_rdata),
    .fetch_taken (fetch_taken)
  );

  btac btac_i (
    .clock             (clock),
    .reset             (reset),
    .clear             (clear),
    .get_pc            (get_pc),
    .resolve_valid     (resolve_valid),
    .resolve_taken     (resolve_taken),
    .resolve_pc        (resolve_pc),
    .resolve_target    (resolve_target),
    .resolve_predicted (resolve_predicted),
    .resolve_ptarget   (resolve_ptarget),
    .pred_branch       (pred_branch),
    .pred_baddr        (pred_baddr),
    .pred_pc           (pred_pc),
    .pred_miss         (pred_miss),
    .pred_maddr        (pred_maddr)
  );

  itim itim_i (
    .clock      (clock),
    .reset      (reset),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .mem_valid  (mem_valid),
    .mem_spec   (mem_spec),
    .mem_fence  (mem_fence),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata)
  );

endmodule

/* testbench/fetch_tb.sv */
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_tb import fetch_pkg::*; ();

  localparam int PHASES       = 8;
  localparam int CYCLES_EACH  = 200;
  localparam int RESET_CYCLES = 8;
  localparam int TABLE_W      = $clog2(`BTAC_DEPTH);
  localparam int MEM_W        = $clog2(`ITIM_DEPTH);

  logic  clock;
  logic  reset;
  logic  trap;
  logic  mret;
  addr_t mtvec;
  addr_t mepc;
  logic  fence;
  addr_t fence_npc;
  logic  clear;
  logic  stall;
  logic  resolve_valid;
  addr_t resolve_pc;
  logic  resolve_taken;
  addr_t resolve_target;
  logic  resolve_predicted;
  addr_t resolve_ptarget;
  logic  load_valid;
  addr_t load_addr;
  word_t load_data;
  logic  fetch_ready;
  addr_t fetch_pc;
  word_t fetch_rdata;
  logic  fetch_taken;
  addr_t fetch_taddr;
  addr_t fetch_tpc;

  int    seed;
  string phase;

  // Reference copies of the itim and the btac
  word_t                  model_mem    [`ITIM_DEPTH];
  logic [`BTAC_DEPTH-1:0] table_valid;
  addr_t                  table_tag    [`BTAC_DEPTH];
  addr_t                  table_target [`BTAC_DEPTH];

  addr_t exp_pc;
  word_t exp_data;
  logic  exp_taken;
  addr_t exp_target;
  logic  miss;
  logic  redirect;
  addr_t redirect_pc;

  fetch_top dut_i (
    .clock             (clock),
    .reset             (reset),
    .trap              (trap),
    .mret              (mret),
    .mtvec             (mtvec),
    .mepc              (mepc),
    .fence             (fence),
    .fence_npc         (fence_npc),
    .clear             (clear),
    .stall             (stall),
    .resolve_valid     (resolve_valid),
    .resolve_pc        (resolve_pc),
    .resolve_taken     (resolve_taken),
    .resolve_target    (resolve_target),
    .resolve_predicted (resolve_predicted),
    .resolve_ptarget   (resolve_ptarget),
    .load_valid        (load_valid),
    .load_addr         (load_addr),
    .load_data         (load_data),
    .fetch_ready       (fetch_ready),
    .fetch_pc          (fetch_pc),
    .fetch_rdata       (fetch_rdata),
    .fetch_taken       (fetch_taken),
    .fetch_taddr       (fetch_taddr),
    .fetch_tpc         (fetch_tpc)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [TABLE_W-1:0] table_index(addr_t pc);
    return TABLE_W'((pc / `FETCH_STEP) % `BTAC_DEPTH);
  endfunction

  function automatic logic [MEM_W-1:0] word_index(addr_t addr);
    return MEM_W'((addr / `FETCH_STEP) % `ITIM_DEPTH);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  assign exp_data   = model_mem[word_index(exp_pc)];
  assign exp_taken  = table_valid[table_index(exp_pc)] &&
                      (table_tag[table_index(exp_pc)] == exp_pc);
  assign exp_target = table_target[table_index(exp_pc)];

  // trap, then mret, then misprediction, then fence
  always_comb begin
    miss = 1'b0;
    if (resolve_valid) begin
      miss = (resolve_taken != resolve_predicted) ||
             (resolve_taken && (resolve_target != resolve_ptarget));
    end
    redirect = trap || mret || miss || fence;
    if (trap) begin
      redirect_pc = mtvec;
    end else if (mret) begin
      redirect_pc = mepc;
    end else if (miss) begin
      redirect_pc = resolve_taken ? resolve_target : resolve_pc + addr_t'(`FETCH_STEP);
    end else begin
      redirect_pc = fence_npc;
    end
  end

  always @(posedge clock) begin : pc_model
    addr_t next_pc;
    next_pc = exp_pc;
    if (fetch_ready) begin
      next_pc = exp_taken ? exp_target : exp_pc + addr_t'(`FETCH_STEP);
    end
    if (redirect) begin
      next_pc = redirect_pc;
    end
    if (!reset) begin
      next_pc = addr_t'(`RESET_PC);
    end
    exp_pc <= next_pc;
  end

  always @(posedge clock) begin
    if (!reset || clear) begin
      table_valid <= '0;
    end else if (resolve_valid) begin
      table_valid[table_index(resolve_pc)] <= resolve_taken;
      if (resolve_taken) begin
        table_tag[table_index(resolve_pc)]    <= resolve_pc;
        table_target[table_index(resolve_pc)] <= resolve_target;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("Error in phase %s: %s expected 0x%0h, actual 0x%0h",
             phase, what, expected, actual);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic report_problem(input string text);
    $display("Phase %s: %s", phase, text);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at the first failing check");
  endtask

  pc_order: assert property (
    @(posedge clock) disable iff (!reset)
    fetch_ready |-> fetch_pc == exp_pc
  ) else report_mismatch("fetch_pc", 64'($sampled(exp_pc)), 64'($sampled(fetch_pc)));

  data_match: assert property (
    @(posedge clock) disable iff (!reset)
    fetch_ready |-> fetch_rdata == exp_data
  ) else report_mismatch("fetch_rdata", $sampled(exp_data), $sampled(fetch_rdata));

  taken_match: assert property (
    @(posedge clock) disable iff (!reset)
    fetch_ready |-> fetch_taken == exp_taken
  ) else report_mismatch("fetch_taken", 64'($sampled(exp_taken)),
                         64'($sampled(fetch_taken)));

  taddr_match: assert property (
    @(posedge clock) disable iff (!reset)
    fetch_ready && exp_taken |-> fetch_taddr == exp_target
  ) else report_mismatch("fetch_taddr", 64'($sampled(exp_target)),
                         64'($sampled(fetch_taddr)));

  tpc_match: assert property (
    @(posedge clock) disable iff (!reset)
    fetch_ready && exp_taken |-> fetch_tpc == exp_pc
  ) else report_mismatch("fetch_tpc", 64'($sampled(exp_pc)), 64'($sampled(fetch_tpc)));

  stall_quiet: assert property (
    @(posedge clock) disable iff (!reset)
    stall |=> !fetch_ready
  ) else report_problem("fetch_ready was high while stall was held");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_fetches(input int count);
    int seen;
    seen = 0;
    while (seen < count) begin
      @(negedge clock);
      if (fetch_ready) begin
        seen++;
      end
    end
  endtask

  task automatic pulse_trap_mret(input logic do_trap, input logic do_mret,
                                 input addr_t vec, input addr_t epc);
    @(negedge clock);
    trap  = do_trap;
    mret  = do_mret;
    mtvec = vec;
    mepc  = epc;
    @(negedge clock);
    trap = 1'b0;
    mret = 1'b0;
  endtask

  task automatic pulse_fence(input addr_t npc);
    @(negedge clock);
    fence     = 1'b1;
    fence_npc = npc;
    @(negedge clock);
    fence = 1'b0;
  endtask

  task automatic send_resolve(input addr_t pc, input logic taken, input addr_t target,
                              input logic predicted, input addr_t ptarget);
    @(negedge clock);
    resolve_valid     = 1'b1;
    resolve_pc        = pc;
    resolve_taken     = taken;
    resolve_target    = target;
    resolve_predicted = predicted;
    resolve_ptarget   = ptarget;
    @(negedge clock);
    resolve_valid = 1'b0;
  endtask

  task automatic hold_level(input bit use_stall, input int cycles);
    @(negedge clock);
    if (use_stall) begin
      stall = 1'b1;
    end else begin
      clear = 1'b1;
    end
    repeat (cycles) @(negedge clock);
    stall = 1'b0;
    clear = 1'b0;
  endtask

  initial begin
    reset             = 1'b0;
    trap              = 1'b0;
    mret              = 1'b0;
    mtvec             = '0;
    mepc              = '0;
    fence             = 1'b0;
    fence_npc         = '0;
    clear             = 1'b1;
    stall             = 1'b0;
    resolve_valid     = 1'b0;
    resolve_pc        = '0;
    resolve_taken     = 1'b0;
    resolve_target    = '0;
    resolve_predicted = 1'b0;
    resolve_ptarget   = '0;
    load_valid        = 1'b0;
    load_addr         = '0;
    load_data         = '0;
    seed              = 16;

    // Load runs through reset, clear keeps the stage parked until done
    phase = "load";
    for (int i = 0; i < `ITIM_DEPTH; i++) begin
      model_mem[MEM_W'(i)] = {32'($random(seed)) ^ 32'(i), 32'($random(seed)) ^ 32'(i * 5)};
    end
    for (int i = 0; i < `ITIM_DEPTH; i++) begin
      @(negedge clock);
      if (i == RESET_CYCLES - 1) begin
        reset = 1'b1;
      end
      load_valid = 1'b1;
      load_addr  = addr_t'(i * `FETCH_STEP);
      load_data  = model_mem[MEM_W'(i)];
    end
    @(negedge clock);
    load_valid = 1'b0;
    clear      = 1'b0;

    phase = "sequential";
    wait_fetches(12);

    phase = "trap_mret";
    pulse_trap_mret(1'b1, 1'b0, 32'h100, 32'h0);
    wait_fetches(3);
    pulse_trap_mret(1'b0, 1'b1, 32'h0, 32'h180);
    wait_fetches(3);
    pulse_trap_mret(1'b1, 1'b1, 32'h0c0, 32'h7f0);
    wait_fetches(3);

    phase = "fence";
    pulse_fence(32'h400);
    wait_fetches(4);

    // Train 0x200 -> 0x340, then steer the stream through it
    phase = "prediction";
    send_resolve(32'h200, 1'b1, 32'h340, 1'b1, 32'h340);
    pulse_trap_mret(1'b1, 1'b0, 32'h1e0, 32'h0);
    wait_fetches(7);

    phase = "mispredict";
    send_resolve(32'h508, 1'b1, 32'h080, 1'b0, 32'h0);
    wait_fetches(3);
    send_resolve(32'h200, 1'b0, 32'h0, 1'b1, 32'h340);
    wait_fetches(3);
    send_resolve(32'h300, 1'b1, 32'h180, 1'b1, 32'h100);
    wait_fetches(3);

    phase = "clear";
    send_resolve(32'h200, 1'b1, 32'h340, 1'b1, 32'h340);
    pulse_trap_mret(1'b1, 1'b0, 32'h1f0, 32'h0);
    wait_fetches(4);
    hold_level(1'b0, 3);
    wait_fetches(2);
    pulse_trap_mret(1'b1, 1'b0, 32'h1f0, 32'h0);
    wait_fetches(4);

    phase = "stall";
    hold_level(1'b1, 12);
    wait_fetches(4);

    $display("TESTS PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (PHASES * CYCLES_EACH) @(posedge clock);
    $display("Timeout: the fetch tests did not finish within %0d cycles",
             PHASES * CYCLES_EACH);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* sources.f */
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_stage.sv
hdl/btac.sv
hdl/itim.sv
hdl/fetch_top.sv
testbench/fetch_tb.sv

/* Makefile */
# Verilator flow for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TESTS PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The simulator exit code is ignored; the log decides pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
